/* src/rmt_parser_pkg.sv */
`default_nettype none

package rmt_parser_pkg;

	// stream side and header window
	localparam int DATA_W = 256;
	localparam int HDR_W = 1024;
	localparam int SEG_NUM = HDR_W / DATA_W;
	localparam int SEG_CNT_W = $clog2(SEG_NUM + 1);
	localparam int VLAN_LSB = 116;
	// entry select is vlan id bits 7..4
	localparam int VLAN_ENTRY_LSB = VLAN_LSB + 4;

	// parse action table
	localparam int ENTRY_NUM = 16;
	localparam int ENTRY_ADDR_W = $clog2(ENTRY_NUM);
	localparam int PARSE_ACT_NUM = 10;
	localparam int COND_NUM = 5;
	localparam int ACT_W = 16;
	localparam int COND_W = 20;
	localparam int ENTRY_W = PARSE_ACT_NUM * ACT_W + COND_NUM * COND_W;

	// fields of one parse action
	localparam int ACT_EN_BIT = 0;
	localparam int ACT_IDX_LSB = 1;
	localparam int ACT_IDX_W = 3;
	localparam int ACT_SIZE_LSB = 4;
	localparam int ACT_SIZE_W = 2;
	localparam int ACT_OFF_LSB = 6;
	localparam int ACT_OFF_W = 7;
	localparam logic [ACT_SIZE_W-1:0] SZ_2B = 2'd1;
	localparam logic [ACT_SIZE_W-1:0] SZ_4B = 2'd2;
	localparam logic [ACT_SIZE_W-1:0] SZ_6B = 2'd3;

	// phv layout
	localparam int CONT_NUM = 8;
	localparam int C6_W = 48;
	localparam int C4_W = 32;
	localparam int C2_W = 16;
	localparam int META_W = 256;
	localparam int PHV_W = CONT_NUM * (C6_W + C4_W + C2_W) + COND_NUM * COND_W + META_W;

	// axi4-lite config port
	localparam int AXIL_ADDR_W = 12;
	localparam int AXIL_DATA_W = 32;
	localparam int ENTRY_WORDS = 9;
	// last word only carries the top bits of an entry
	localparam int ENTRY_TOP_W = ENTRY_W - (ENTRY_WORDS - 1) * AXIL_DATA_W;
	localparam int WORD_SEL_LSB = 2;
	localparam int WORD_SEL_W = 4;
	localparam int ENTRY_SEL_LSB = 6;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// action 0 in the top 16 bits, condition word 0 at bit 0
	typedef union packed {
		logic [ENTRY_W-1:0] raw;
		struct packed {
			logic [0:PARSE_ACT_NUM-1][ACT_W-1:0] act;
			logic [COND_NUM-1:0][COND_W-1:0] cond;
		} fields;
	} parse_entry_u;

endpackage

`default_nettype wire

/* src/parse_cfg_axil.sv */
`timescale 1ns/10ps
`default_nettype none

module parse_cfg_axil (
	input  logic axis_clk,
	input  logic aresetn,

	input  logic [rmt_parser_pkg::AXIL_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [rmt_parser_pkg::AXIL_DATA_W-1:0] wdata,
	input  logic [rmt_parser_pkg::AXIL_DATA_W/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,

	input  logic [rmt_parser_pkg::AXIL_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [rmt_parser_pkg::AXIL_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,

	output logic ram_we,
	output logic [rmt_parser_pkg::ENTRY_ADDR_W-1:0] ram_waddr,
	output rmt_parser_pkg::parse_entry_u ram_wdata
);
	import rmt_parser_pkg::*;

	logic [AXIL_DATA_W-1:0] stage [ENTRY_WORDS];
	logic [WORD_SEL_W-1:0] aw_word;
	logic [WORD_SEL_W-1:0] ar_word;
	logic wr_ok;
	logic rd_ok;
	logic wr_fire;
	logic rd_fire;
	logic [AXIL_DATA_W-1:0] wr_merged;

	function automatic logic [AXIL_DATA_W-1:0] merge_strb(
		input logic [AXIL_DATA_W-1:0] old_word,
		input logic [AXIL_DATA_W-1:0] new_word,
		input logic [AXIL_DATA_W/8-1:0] strb
	);
		logic [AXIL_DATA_W-1:0] res;
		res = old_word;
		for (int b = 0; b < AXIL_DATA_W / 8; b++) begin
			if (strb[b])
				res[b*8 +: 8] = new_word[b*8 +: 8];
		end
		return res;
	endfunction

	assign aw_word = awaddr[WORD_SEL_LSB +: WORD_SEL_W];
	assign ar_word = araddr[WORD_SEL_LSB +: WORD_SEL_W];
	assign wr_ok = aw_word < ENTRY_WORDS;
	assign rd_ok = ar_word < ENTRY_WORDS;

	// idle means no response outstanding
	assign awready = !bvalid;
	assign wready = !bvalid;
	assign arready = !rvalid;

	// address and data are taken in the same cycle
	assign wr_fire = awvalid && wvalid && !bvalid;
	assign rd_fire = arvalid && arready;

	assign wr_merged = merge_strb(wr_ok ? stage[aw_word] : '0, wdata, wstrb);

	// word 8 commits the staged entry straight away
	assign ram_we = wr_fire && (aw_word == ENTRY_WORDS - 1);
	assign ram_waddr = awaddr[ENTRY_SEL_LSB +: ENTRY_ADDR_W];

	always_comb begin
		for (int i = 0; i < ENTRY_WORDS - 1; i++)
			ram_wdata.raw[i*AXIL_DATA_W +: AXIL_DATA_W] = stage[i];
		ram_wdata.raw[ENTRY_W-1 -: ENTRY_TOP_W] = wr_merged[ENTRY_TOP_W-1:0];
	end

	always_ff @(posedge axis_clk or negedge aresetn) begin
		if (!aresetn) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// staging words and response payload
	always_ff @(posedge axis_clk) begin
		if (wr_fire) begin
			bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
			if (wr_ok)
				stage[aw_word] <= wr_merged;
		end
		if (rd_fire) begin
			rdata <= rd_ok ? stage[ar_word] : '0;
			rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

endmodule

`default_nettype wire

/* src/parse_action_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module parse_action_ram (
	input  logic axis_clk,

	// config write port
	input  logic ram_we,
	input  logic [rmt_parser_pkg::ENTRY_ADDR_W-1:0] ram_waddr,
	input  rmt_parser_pkg::parse_entry_u ram_wdata,

	// lookup port
	input  logic act_rd,
	input  logic [rmt_parser_pkg::ENTRY_ADDR_W-1:0] act_addr,
	output rmt_parser_pkg::parse_entry_u act_entry
);
	import rmt_parser_pkg::*;

	// all entries start out as no-op actions
	parse_entry_u mem [ENTRY_NUM] = '{default: '0};

	always_ff @(posedge axis_clk) begin
		if (ram_we)
			mem[ram_waddr] <= ram_wdata;
	end

	// output holds until the next lookup
	always_ff @(posedge axis_clk) begin
		if (act_rd)
			act_entry <= mem[act_addr];
	end

endmodule

`default_nettype wire

/* src/hdr_capture.sv */
`timescale 1ns/10ps
`default_nettype none

module hdr_capture (
	input  logic axis_clk,
	input  logic aresetn,

	input  logic [rmt_parser_pkg::DATA_W-1:0] s_axis_tdata,
	input  logic s_axis_tvalid,
	input  logic s_axis_tlast,

	output logic act_rd,
	output logic [rmt_parser_pkg::ENTRY_ADDR_W-1:0] act_addr,
	output logic hdr_done,
	output logic [rmt_parser_pkg::HDR_W-1:0] hdr_window
);
	import rmt_parser_pkg::*;

	logic mid_pkt;
	logic [SEG_CNT_W-1:0] seg_cnt;
	logic first_beat;
	logic [SEG_CNT_W-1:0] seg_idx;
	logic take_beat;
	logic last_take;

	// packet start follows tlast, not the edge of tvalid
	assign first_beat = s_axis_tvalid && !mid_pkt;
	assign seg_idx = first_beat ? '0 : seg_cnt;

	// only the first SEG_NUM beats land in the window
	assign take_beat = s_axis_tvalid && (seg_idx < SEG_NUM);
	assign last_take = take_beat && ((seg_idx == SEG_NUM - 1) || s_axis_tlast);

	always_ff @(posedge axis_clk or negedge aresetn) begin
		if (!aresetn) begin
			mid_pkt <= 1'b0;
			seg_cnt <= '0;
			act_rd <= 1'b0;
			hdr_done <= 1'b0;
		end else begin
			act_rd <= first_beat;
			hdr_done <= last_take;
			if (s_axis_tvalid)
				mid_pkt <= !s_axis_tlast;
			if (take_beat)
				seg_cnt <= seg_idx + 1'b1;
		end
	end

	always_ff @(posedge axis_clk) begin
		if (first_beat) begin
			act_addr <= s_axis_tdata[VLAN_ENTRY_LSB +: ENTRY_ADDR_W];
			// lower slices stay zero for short packets
			hdr_window <= {s_axis_tdata, {(HDR_W - DATA_W){1'b0}}};
		end else if (take_beat) begin
			hdr_window[HDR_W - 1 - seg_idx * DATA_W -: DATA_W] <= s_axis_tdata;
		end
	end

endmodule

`default_nettype wire

/* src/phv_extract.sv */
`timescale 1ns/10ps
`default_nettype none

module phv_extract (
	input  logic axis_clk,
	input  logic aresetn,

	input  logic hdr_done,
	input  logic [rmt_parser_pkg::HDR_W-1:0] hdr_window,
	input  rmt_parser_pkg::parse_entry_u act_entry,

	output logic [rmt_parser_pkg::PHV_W-1:0] phv_out,
	output logic phv_valid
);
	import rmt_parser_pkg::*;

	// zero pad so fields past the window end read as zero
	logic [HDR_W+C6_W-1:0] hdr_ext;

	logic [CONT_NUM-1:0][C6_W-1:0] c6_nxt;
	logic [CONT_NUM-1:0][C4_W-1:0] c4_nxt;
	logic [CONT_NUM-1:0][C2_W-1:0] c2_nxt;
	logic [CONT_NUM-1:0][C6_W-1:0] c6_q;
	logic [CONT_NUM-1:0][C4_W-1:0] c4_q;
	logic [CONT_NUM-1:0][C2_W-1:0] c2_q;
	// word 0 ends up highest in the phv
	logic [0:COND_NUM-1][COND_W-1:0] cond_q;

	assign hdr_ext = {{C6_W{1'b0}}, hdr_window};

	// actions in order, so a later one wins on the same container
	always_comb begin
		logic [ACT_W-1:0] act;
		logic [C6_W-1:0] fld;
		logic [ACT_IDX_W-1:0] idx;
		c6_nxt = '0;
		c4_nxt = '0;
		c2_nxt = '0;
		for (int a = 0; a < PARSE_ACT_NUM; a++) begin
			act = act_entry.fields.act[a];
			idx = act[ACT_IDX_LSB +: ACT_IDX_W];
			// byte offset to bit offset
			fld = hdr_ext[{act[ACT_OFF_LSB +: ACT_OFF_W], 3'b000} +: C6_W];
			if (act[ACT_EN_BIT]) begin
				case (act[ACT_SIZE_LSB +: ACT_SIZE_W])
					SZ_2B: c2_nxt[idx] = fld[C2_W-1:0];
					SZ_4B: c4_nxt[idx] = fld[C4_W-1:0];
					SZ_6B: c6_nxt[idx] = fld;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge axis_clk or negedge aresetn) begin
		if (!aresetn)
			phv_valid <= 1'b0;
		else
			phv_valid <= hdr_done;
	end

	// condition words are latched too, act_entry moves on with the next packet
	always_ff @(posedge axis_clk) begin
		if (hdr_done) begin
			c6_q <= c6_nxt;
			c4_q <= c4_nxt;
			c2_q <= c2_nxt;
			for (int c = 0; c < COND_NUM; c++)
				cond_q[c] <= act_entry.fields.cond[c];
		end
	end

	// metadata bits not generated here
	assign phv_out = {c6_q, c4_q, c2_q, cond_q, {META_W{1'b0}}};

endmodule

`default_nettype wire

/* src/rmt_parser_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rmt_parser_top (
	input  logic axis_clk,
	input  logic aresetn,

	// table config
	input  logic [rmt_parser_pkg::AXIL_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [rmt_parser_pkg::AXIL_DATA_W-1:0] wdata,
	input  logic [rmt_parser_pkg::AXIL_DATA_W/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [rmt_parser_pkg::AXIL_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [rmt_parser_pkg::AXIL_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,

	// packet stream, always accepted
	input  logic [rmt_parser_pkg::DATA_W-1:0] s_axis_tdata,
	input  logic s_axis_tvalid,
	input  logic s_axis_tlast,

	output logic [rmt_parser_pkg::PHV_W-1:0] phv_out,
	output logic phv_valid
);
	import rmt_parser_pkg::*;

	logic ram_we;
	logic [ENTRY_ADDR_W-1:0] ram_waddr;
	parse_entry_u ram_wdata;
	logic act_rd;
	logic [ENTRY_ADDR_W-1:0] act_addr;
	parse_entry_u act_entry;
	logic hdr_done;
	logic [HDR_W-1:0] hdr_window;

	parse_cfg_axil parse_cfg_axil_i (
		.axis_clk(axis_clk), .aresetn(aresetn),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.ram_we(ram_we), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata)
	);

	parse_action_ram parse_action_ram_i (
		.axis_clk(axis_clk),
		.ram_we(ram_we), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata),
		.act_rd(act_rd), .act_addr(act_addr), .act_entry(act_entry)
	);

	hdr_capture hdr_capture_i (
		.axis_clk(axis_clk), .aresetn(aresetn),
		.s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid),
		.s_axis_tlast(s_axis_tlast),
		.act_rd(act_rd), .act_addr(act_addr),
		.hdr_done(hdr_done), .hdr_window(hdr_window)
	);

	phv_extract phv_extract_i (
		.axis_clk(axis_clk), .aresetn(aresetn),
		.hdr_done(hdr_done), .hdr_window(hdr_window), .act_entry(act_entry),
		.phv_out(phv_out), .phv_valid(phv_valid)
	);

endmodule

`default_nettype wire

/* verification/tb_rmt_parser.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rmt_parser;
	import rmt_parser_pkg::*;

	localparam int TIMEOUT = 200;

	logic axis_clk = 1'b0;
	logic aresetn;
	logic [AXIL_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [AXIL_DATA_W-1:0] wdata;
	logic [AXIL_DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXIL_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [AXIL_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [DATA_W-1:0] s_axis_tdata;
	logic s_axis_tvalid;
	logic s_axis_tlast;
	logic [PHV_W-1:0] phv_out;
	logic phv_valid;

	int seed = 32'h2f03e412;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int err_mark = 0;
	logic [PHV_W-1:0] exp_q [$];
	// testbench view of the staging buffer and the table
	logic [AXIL_DATA_W-1:0] stage_model [ENTRY_WORDS];
	parse_entry_u shadow [ENTRY_NUM];

	rmt_parser_top rmt_parser_top_i (.*);

	always #20 axis_clk = ~axis_clk;

	task automatic abort_run(input string why);
		$display("timeout at %0t: %s", $time, why);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic check_phv(input logic [PHV_W-1:0] got, input logic [PHV_W-1:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_word(input logic [AXIL_DATA_W-1:0] got,
			input logic [AXIL_DATA_W-1:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// one action placed in its slot, action 0 on top
	function automatic logic [ENTRY_W-1:0] act_at(input int a, input logic en,
			input logic [2:0] idx, input logic [1:0] size, input logic [6:0] off);
		logic [ENTRY_W-1:0] r;
		r = '0;
		r[ENTRY_W - 1 - a * ACT_W -: ACT_W] = {3'b000, off, size, idx, en};
		return r;
	endfunction

	function automatic logic [HDR_W-1:0] rand_hdr(input logic [3:0] ent);
		logic [HDR_W-1:0] h;
		for (int i = 0; i < HDR_W / 32; i++)
			h[i * 32 +: 32] = $random(seed);
		// vlan id bits 7..4 of the first beat pick the entry
		h[HDR_W - DATA_W + VLAN_LSB + 4 +: 4] = ent;
		return h;
	endfunction

	function automatic parse_entry_u rand_entry();
		logic [ENTRY_WORDS*32-1:0] r;
		parse_entry_u e;
		for (int i = 0; i < ENTRY_WORDS; i++)
			r[i * 32 +: 32] = $random(seed);
		e.raw = r[ENTRY_W-1:0];
		return e;
	endfunction

	function automatic logic [PHV_W-1:0] phv_model(input logic [HDR_W-1:0] win,
			input parse_entry_u ent);
		logic [47:0] c6 [CONT_NUM];
		logic [31:0] c4 [CONT_NUM];
		logic [15:0] c2 [CONT_NUM];
		logic [15:0] act;
		logic [47:0] fld;
		logic [PHV_W-1:0] phv;
		int base;
		int pos;
		for (int k = 0; k < CONT_NUM; k++) begin
			c6[k] = '0;
			c4[k] = '0;
			c2[k] = '0;
		end
		for (int a = 0; a < PARSE_ACT_NUM; a++) begin
			act = ent.raw[ENTRY_W - 1 - a * 16 -: 16];
			base = 8 * int'(act[12:6]);
			fld = '0;
			// bits above the window stay zero
			for (int b = 0; b < 48; b++)
				if (base + b < HDR_W)
					fld[b] = win[base + b];
			if (act[0]) begin
				case (act[5:4])
					2'd1: c2[act[3:1]] = fld[15:0];
					2'd2: c4[act[3:1]] = fld[31:0];
					2'd3: c6[act[3:1]] = fld;
					default: ;
				endcase
			end
		end
		phv = '0;
		pos = PHV_W;
		for (int k = CONT_NUM - 1; k >= 0; k--) begin
			pos -= 48;
			phv[pos +: 48] = c6[k];
		end
		for (int k = CONT_NUM - 1; k >= 0; k--) begin
			pos -= 32;
			phv[pos +: 32] = c4[k];
		end
		for (int k = CONT_NUM - 1; k >= 0; k--) begin
			pos -= 16;
			phv[pos +: 16] = c2[k];
		end
		for (int c = 0; c < COND_NUM; c++) begin
			pos -= 20;
			phv[pos +: 20] = ent.raw[c * 20 +: 20];
		end
		return phv;
	endfunction

	task automatic axil_write(input logic [3:0] ent, input logic [3:0] word,
			input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] mask;
		logic [1:0] resp;
		int t;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		@(posedge axis_clk);
		awaddr <= {2'b00, ent, word, 2'b00};
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= strb;
		wvalid <= 1'b1;
		t = 0;
		do begin
			@(negedge axis_clk);
			if (++t > TIMEOUT) abort_run("write stalled, awready and wready never both high");
		end while (!(awready && wready));
		@(posedge axis_clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bready <= 1'b1;
		t = 0;
		do begin
			@(negedge axis_clk);
			if (++t > TIMEOUT) abort_run("write response stalled, bvalid never rose");
		end while (!bvalid);
		resp = bresp;
		@(posedge axis_clk);
		bready <= 1'b0;
		if (int'(word) < ENTRY_WORDS) begin
			check_resp(resp, RESP_OKAY, "write response");
			stage_model[word] = (stage_model[word] & ~mask) | (data & mask);
			// last word commits the whole staged entry
			if (int'(word) == ENTRY_WORDS - 1)
				shadow[ent].raw = {stage_model[8][3:0], stage_model[7], stage_model[6],
					stage_model[5], stage_model[4], stage_model[3], stage_model[2],
					stage_model[1], stage_model[0]};
		end else begin
			check_resp(resp, RESP_SLVERR, "unmapped write response");
		end
	endtask

	task automatic axil_read(input logic [3:0] ent, input logic [3:0] word);
		logic [31:0] data;
		logic [1:0] resp;
		int t;
		@(posedge axis_clk);
		araddr <= {2'b00, ent, word, 2'b00};
		arvalid <= 1'b1;
		t = 0;
		do begin
			@(negedge axis_clk);
			if (++t > TIMEOUT) abort_run("read address stalled, arready never high");
		end while (!arready);
		@(posedge axis_clk);
		arvalid <= 1'b0;
		rready <= 1'b1;
		t = 0;
		do begin
			@(negedge axis_clk);
			if (++t > TIMEOUT) abort_run("read data stalled, rvalid never rose");
		end while (!rvalid);
		data = rdata;
		resp = rresp;
		@(posedge axis_clk);
		rready <= 1'b0;
		if (int'(word) < ENTRY_WORDS) begin
			check_resp(resp, RESP_OKAY, "read response");
			check_word(data, stage_model[word], "staging readback");
		end else begin
			check_resp(resp, RESP_SLVERR, "unmapped read response");
			check_word(data, '0, "unmapped read data");
		end
	endtask

	task automatic load_entry(input logic [3:0] ent, input parse_entry_u e);
		for (int w = 0; w < ENTRY_WORDS - 1; w++)
			axil_write(ent, 4'(w), e.raw[w * 32 +: 32], 4'hf);
		axil_write(ent, 4'(ENTRY_WORDS - 1), {28'd0, e.raw[ENTRY_W-1 -: 4]}, 4'hf);
	endtask

	// beats past the fourth carry filler that the parser drops
	task automatic send_packet(input logic [HDR_W-1:0] hdr, input int beats);
		logic [HDR_W-1:0] win;
		logic [HDR_W-1:0] fill;
		logic [3:0] ent;
		win = hdr;
		for (int i = beats; i < SEG_NUM; i++)
			win[HDR_W - 1 - i * DATA_W -: DATA_W] = '0;
		ent = hdr[HDR_W - DATA_W + VLAN_LSB + 4 +: 4];
		exp_q.push_back(phv_model(win, shadow[ent]));
		for (int i = 0; i < beats; i++) begin
			@(posedge axis_clk);
			s_axis_tvalid <= 1'b1;
			s_axis_tlast <= (i == beats - 1);
			if (i < SEG_NUM) begin
				s_axis_tdata <= hdr[HDR_W - 1 - i * DATA_W -: DATA_W];
			end else begin
				fill = rand_hdr(4'd0);
				s_axis_tdata <= fill[DATA_W-1:0];
			end
		end
	endtask

	task automatic end_stream();
		@(posedge axis_clk);
		s_axis_tvalid <= 1'b0;
		s_axis_tlast <= 1'b0;
	endtask

	task automatic test_done(input string name);
		int t;
		t = 0;
		while (exp_q.size() != 0) begin
			@(negedge axis_clk);
			if (++t > TIMEOUT) abort_run("phv_valid never came for a sent packet");
		end
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "errors");
		err_mark = errors;
	endtask

	// each phv_valid pulse is matched against the oldest pending packet
	always @(negedge axis_clk) begin
		if (phv_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("unexpected phv_valid at %0t with no packet pending", $time);
			end else begin
				check_phv(phv_out, exp_q.pop_front(), "phv");
			end
		end
	end

	initial begin
		parse_entry_u e;
		aresetn = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		s_axis_tdata = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
		for (int i = 0; i < ENTRY_WORDS; i++)
			stage_model[i] = '0;
		for (int i = 0; i < ENTRY_NUM; i++)
			shadow[i] = '0;
		repeat (2) @(posedge axis_clk);
		aresetn <= 1'b1;

		// full words first, then alternating byte strobes
		for (int w = 0; w < ENTRY_WORDS; w++)
			axil_write(4'd15, 4'(w), $random(seed), 4'hf);
		for (int w = 0; w < ENTRY_WORDS; w++)
			axil_write(4'd15, 4'(w), $random(seed), w[0] ? 4'b1010 : 4'b0101);
		for (int w = 0; w < ENTRY_WORDS; w++)
			axil_read(4'd15, 4'(w));
		test_done("staging write and readback");

		// all size classes, one field running past the window end
		e = rand_entry();
		e.raw[ENTRY_W - 1 -: PARSE_ACT_NUM * ACT_W] = '0;
		for (int a = 0; a < PARSE_ACT_NUM; a++)
			e.raw = e.raw | act_at(a, 1'b1, 3'(a * 5), 2'(a % 3 + 1), 7'((a * 29 + 11) % 128));
		load_entry(4'd3, e);
		send_packet(rand_hdr(4'd3), 4);
		end_stream();
		test_done("four beat packet");

		send_packet(rand_hdr(4'd3), 2);
		end_stream();
		test_done("two beat packet");

		e.raw = act_at(0, 1'b1, 3'd2, 2'd2, 7'd8) | act_at(1, 1'b0, 3'd5, 2'd3, 7'd50)
			| act_at(2, 1'b1, 3'd2, 2'd2, 7'd90) | act_at(3, 1'b1, 3'd7, 2'd1, 7'd33);
		load_entry(4'd5, e);
		e.raw = act_at(0, 1'b1, 3'd0, 2'd1, 7'd20) | act_at(1, 1'b1, 3'd0, 2'd1, 7'd21)
			| act_at(2, 1'b0, 3'd3, 2'd3, 7'd5) | act_at(3, 1'b1, 3'd6, 2'd3, 7'd110);
		load_entry(4'd9, e);
		send_packet(rand_hdr(4'd5), 4);
		send_packet(rand_hdr(4'd9), 4);
		end_stream();
		test_done("disabled and overlapping actions");

		for (int i = 0; i < ENTRY_NUM; i++)
			load_entry(4'(i), rand_entry());
		for (int p = 0; p < 20; p++)
			send_packet(rand_hdr(4'($random(seed))), 2 + ($unsigned($random(seed)) % 5));
		end_stream();
		test_done("random back to back packets");

		axil_write(4'd3, 4'd10, $random(seed), 4'hf);
		axil_read(4'd3, 4'd10);
		send_packet(rand_hdr(4'd3), 4);
		end_stream();
		test_done("unmapped word write");

		repeat (4) @(negedge axis_clk);
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
src/rmt_parser_pkg.sv
src/parse_cfg_axil.sv
src/parse_action_ram.sv
src/hdr_capture.sv
src/phv_extract.sv
src/rmt_parser_top.sv
verification/tb_rmt_parser.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_rmt_parser
FILELIST ?= all.f
LOG ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -Wno-fatal --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
